// ==== run.sh ====
#!/bin/sh
# build the FPU testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fpuTb -f tb.f -o simFpu

./obj_dir/simFpu | tee sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without failure"

// ==== tb.f ====
+incdir+verification
verilog/fpuPkg.sv
verilog/fpuDecode.sv
verilog/fpRegFile.sv
verilog/fpHazard.sv
verilog/fpCompare.sv
verilog/fpSignClassify.sv
verilog/fpuExecute.sv
verilog/fpuResult.sv
verilog/fpuTop.sv
verification/fpuTb.sv

// ==== verification/fpuTbTasks.svh ====
// fpuTbTasks
// instruction issue, result checks and the directed tests of the FPU testbench
// every task starts and ends right after a rising clock edge

task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
   assert (act === exp)
      else stopOnError($sformatf("FAIL %s expected %h actual %h", name, exp, act));
endtask

// hold the instruction in decode until it moves into execute
task automatic issue(input logic [31:0] instr, input logic [31:0] src, input logic [31:0] ld);
   int   stalls;
   logic moved;
   stalls = 0;
   moved  = 1'b0;
   InstrD <= instr;
   for (int n = 0; n < timeout && !moved; n++) begin
      @(negedge clk);
      checkVal("legal decode", 32'd0, {31'b0, IllegalFPUInstrD});
      if (FStallD) stalls++;
      else moved = 1'b1;
      @(posedge clk);
   end
   if (!moved) stopOnError("instruction held in decode past the timeout");
   lastStalls = stalls;
   InstrD         <= nop;
   ForwardedSrcAE <= src;                   // fmv.w.x reads it in execute
   if (instr[6:0] == 7'b0000111) begin
      fork
         begin
            automatic logic [31:0] data = ld;
            repeat (2) @(posedge clk);
            ReadDataW <= data;              // core returns load data in writeback
         end
      join_none
   end
endtask

// wait for the integer result strobe and check result and NV
task automatic expectInt(input string name, input logic [31:0] exp, input logic nvExp);
   logic seen;
   seen = 1'b0;
   for (int n = 0; n < timeout && !seen; n++) begin
      @(negedge clk);
      seen = FWriteIntM;
      if (seen) begin
         checkVal(name, exp, FIntResM);
         checkVal({name, " flags"}, {27'b0, nvExp, 4'b0}, {27'b0, SetFflagsM});
         checkVal({name, " memory strobe"}, 32'd0, {31'b0, FpLoadStoreM});
      end
      @(posedge clk);
   end
   if (!seen) stopOnError({"no integer result arrived for ", name});
endtask

task automatic expectStore(input string name, input logic [31:0] exp);
   logic seen;
   seen = 1'b0;
   for (int n = 0; n < timeout && !seen; n++) begin
      @(negedge clk);
      seen = FpStoreE;
      if (seen) checkVal(name, exp, FWriteDataE);
      @(posedge clk);
   end
   if (!seen) stopOnError({"no store data arrived for ", name});
endtask

task automatic loadReg(input logic [4:0] rd, input logic [31:0] v);
   issue(fpOp(7'b1111000, 5'd0, 5'd0, 3'd0, rd), v, 32'd0);   // fmv.w.x
   refRegs[rd] = v;
endtask

task automatic readFp(input string name, input logic [4:0] rs);
   issue(fpOp(7'b1110000, 5'd0, rs, 3'd0, 5'd1), 32'd0, 32'd0);   // fmv.x.w into x1
   expectInt(name, refRegs[rs], 1'b0);
endtask

//////////////////////////////////////////////////////////////////////
// directed tests

task automatic testResetState();
   @(negedge clk);
   checkVal("reset", 32'd0,
            {23'd0, FStallD, FpStoreE, FWriteIntM, FpLoadStoreM, SetFflagsM});
   @(posedge clk);
endtask

task automatic testLoadStore();
   logic [31:0] v;
   v = $random(seed);
   issue(flw(5'd5), 32'd0, v);
   refRegs[5] = v;
   issue(fsw(5'd5), 32'd0, 32'd0);          // uses the load target, one stall
   checkVal("flw/fsw stall", 32'd1, lastStalls);
   expectStore("flw/fsw", v);
   InstrD <= fpOp(7'b1111111, 5'd0, 5'd0, 3'd0, 5'd5);   // unknown funct7
   @(negedge clk);
   checkVal("illegal decode", 32'd1, {31'b0, IllegalFPUInstrD});
   checkVal("fsw memory strobe", 32'd1, {31'b0, FpLoadStoreM});   // fsw now in memory
   @(posedge clk);
   readFp("illegal no write", 5'd5);        // f5 must still hold the load
endtask

task automatic testMoves();
   loadReg(5'd6, $random(seed));
   readFp("fmv round trip", 5'd6);
endtask

task automatic testSignInject();
   logic [31:0] a, b;
   for (int k = 0; k < 3; k++) begin
      a = $random(seed);
      b = $random(seed);
      loadReg(5'd1, a);
      loadReg(5'd2, b);
      issue(fpOp(7'b0010000, 5'd2, 5'd1, 3'(k), 5'd3), 32'd0, 32'd0);
      case (k)
         0:       refRegs[3] = {b[31], a[30:0]};
         1:       refRegs[3] = {~b[31], a[30:0]};
         default: refRegs[3] = {a[31] ^ b[31], a[30:0]};
      endcase
      readFp($sformatf("fsgnj funct3 %0d", k), 5'd3);
   end
endtask

task automatic testCompare();
   logic [31:0] xs [6];
   logic [31:0] ys [6];
   logic        nan, snan, zero, eq, lt, res, nv;
   // ordinary, reversed, signed zeros, quiet NaN, signaling NaN, negatives
   xs = '{32'h3F80_0000, 32'h4000_0000, 32'h8000_0000, 32'h7FC0_0000, 32'h7F80_0001,
          32'hBF80_0000};
   ys = '{32'h4000_0000, 32'h3F80_0000, 32'h0000_0000, 32'h3F80_0000, 32'h3F80_0000,
          32'hC000_0000};
   for (int i = 0; i < 6; i++) begin
      loadReg(5'd1, xs[i]);
      loadReg(5'd2, ys[i]);
      nan  = isNaN(xs[i]) || isNaN(ys[i]);
      snan = isSNaN(xs[i]) || isSNaN(ys[i]);
      zero = ((xs[i] | ys[i]) & 32'h7FFF_FFFF) == 32'd0;
      eq   = zero || xs[i] == ys[i];
      lt   = !zero && orderKey(xs[i]) < orderKey(ys[i]);
      for (int f3 = 0; f3 < 3; f3++) begin   // fle, flt, feq
         res = (f3 == 2) ? eq : (f3 == 1) ? lt : (lt | eq);
         nv  = (f3 == 2) ? snan : nan;
         issue(fpOp(7'b1010000, 5'd2, 5'd1, 3'(f3), 5'd1), 32'd0, 32'd0);
         expectInt($sformatf("compare pair %0d funct3 %0d", i, f3), {31'b0, res & !nan}, nv);
      end
   end
endtask

task automatic testMinMax();
   logic [31:0] xs [6];
   logic [31:0] ys [6];
   logic        xLess;
   xs = '{32'h8000_0000, 32'h0000_0000, 32'h7FC0_0000, 32'h3F80_0000, 32'h7FC0_0000, 0};
   ys = '{32'h0000_0000, 32'h8000_0000, 32'h4040_0000, 32'h7F80_0001, 32'hFF80_0001, 0};
   xs[5] = $random(seed);
   ys[5] = $random(seed);
   for (int i = 0; i < 6; i++) begin
      loadReg(5'd1, xs[i]);
      loadReg(5'd2, ys[i]);
      xLess = orderKey(xs[i]) < orderKey(ys[i]);
      for (int f3 = 0; f3 < 2; f3++) begin   // fmin, fmax
         issue(fpOp(7'b0010100, 5'd2, 5'd1, 3'(f3), 5'd3), 32'd0, 32'd0);
         @(posedge clk);
         @(negedge clk);                     // flags sit in memory stage
         checkVal($sformatf("minmax NV pair %0d funct3 %0d", i, f3),
                  {27'b0, isSNaN(xs[i]) || isSNaN(ys[i]), 4'b0}, {27'b0, SetFflagsM});
         @(posedge clk);
         if (isNaN(xs[i]) && isNaN(ys[i])) refRegs[3] = 32'h7FC0_0000;
         else if (isNaN(xs[i]))            refRegs[3] = ys[i];
         else if (isNaN(ys[i]))            refRegs[3] = xs[i];
         else if (f3 == 0)                 refRegs[3] = xLess ? xs[i] : ys[i];
         else                              refRegs[3] = xLess ? ys[i] : xs[i];
         readFp($sformatf("minmax pair %0d funct3 %0d", i, f3), 5'd3);
      end
   end
endtask

task automatic testClassify();
   logic [31:0] vals [10];
   // -inf, -normal, -subnormal, -0, +0, +subnormal, +normal, +inf, sNaN, qNaN
   vals = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000, 32'h0000_0000,
            32'h0000_0001, 32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001, 32'h7FC0_0000};
   for (int i = 0; i < 10; i++) begin
      loadReg(5'd1, vals[i]);
      issue(fpOp(7'b1110000, 5'd0, 5'd1, 3'b001, 5'd1), 32'd0, 32'd0);
      expectInt($sformatf("fclass %0d", i), 32'd1 << i, 1'b0);
   end
endtask

task automatic testForwarding();
   logic [31:0] a, b, v;
   a = $random(seed);
   b = $random(seed);
   v = $random(seed);
   loadReg(5'd1, a);
   loadReg(5'd2, b);
   issue(fpOp(7'b0010000, 5'd2, 5'd1, 3'd2, 5'd3), 32'd0, 32'd0);   // f1 from W, f2 from M
   refRegs[3] = {a[31] ^ b[31], a[30:0]};
   issue(fpOp(7'b0010000, 5'd1, 5'd3, 3'd1, 5'd4), 32'd0, 32'd0);   // f3 from M
   refRegs[4] = {~a[31], refRegs[3][30:0]};
   checkVal("dependent no stall", 32'd0, lastStalls);
   readFp("forwarded chain", 5'd4);
   issue(flw(5'd7), 32'd0, v);
   refRegs[7] = v;
   issue(fpOp(7'b0010000, 5'd7, 5'd7, 3'd0, 5'd8), 32'd0, 32'd0);   // load-use
   checkVal("load-use stall", 32'd1, lastStalls);
   refRegs[8] = v;
   readFp("load-use value", 5'd8);
endtask

// ==== verification/fpuTb.sv ====
`timescale 1ns/1ps
// fpuTb
// testbench of the single-precision FPU pipeline
// issues RV32F instructions into decode, keeps a model of the FP registers
// and checks store data, integer results and the invalid flag

module fpuTb;

   localparam logic [31:0] nop     = 32'h0000_0013;   // integer addi, a bubble for the FPU
   localparam int          timeout = 20;              // cycles any wait may take

   logic        clk, rstN;
   logic [31:0] InstrD, ForwardedSrcAE, ReadDataW;
   logic        FStallD, IllegalFPUInstrD, FpStoreE, FWriteIntM, FpLoadStoreM;
   logic [31:0] FWriteDataE, FIntResM;
   logic [4:0]  SetFflagsM;

   logic [31:0] refRegs [32];   // expected FP register contents
   int          seed;
   int          lastStalls;     // stall cycles of the last issued instruction

   fpuTop DUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // instruction encoders and reference rules

   function automatic logic [31:0] fpOp(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b1010011};
   endfunction

   function automatic logic [31:0] flw(input logic [4:0] rd);
      return {12'h000, 5'd0, 3'b010, rd, 7'b0000111};   // base x0, offset 0
   endfunction

   function automatic logic [31:0] fsw(input logic [4:0] rs2);
      return {7'd0, rs2, 5'd0, 3'b010, 5'd0, 7'b0100111};
   endfunction

   function automatic logic isNaN(input logic [31:0] w);
      return w[30:23] == 8'hFF && w[22:0] != 23'd0;
   endfunction

   function automatic logic isSNaN(input logic [31:0] w);
      return isNaN(w) && !w[22];   // quiet bit clear
   endfunction

   // maps a float onto an unsigned key that sorts like the numbers, -0 below +0
   function automatic logic [31:0] orderKey(input logic [31:0] w);
      return w[31] ? ~w : {1'b1, w[30:0]};
   endfunction

   task automatic stopOnError(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   `include "fpuTbTasks.svh"

   //////////////////////////////////////////////////////////////////////
   // test sequence

   initial begin
      seed           = 32'h3135_b266;
      lastStalls     = 0;
      rstN           = 1'b0;
      InstrD         = nop;
      ForwardedSrcAE = '0;
      ReadDataW      = '0;
      for (int i = 0; i < 32; i++) refRegs[i] = '0;   // register file clears on reset
      repeat (3) @(posedge clk);
      rstN <= 1'b1;
      testResetState();
      testLoadStore();
      testMoves();
      testSignInject();
      testCompare();
      testMinMax();
      testClassify();
      testForwarding();
      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== verilog/fpCompare.sv ====
`timescale 1ns/1ps
// fpCompare
// feq, flt and fle plus fmin and fmax on single-precision operands
// raises the invalid flag according to the RISC-V NaN rules

module fpCompare import fpuPkg::*; (
   input  fpWord_t    FSrcX, FSrcY,
   input  logic [2:0] FOpCtrl,      // 010 eq, 001 lt, 000 le, 100 min, 101 max
   output fpWord_t    CmpIntRes,
   output fpWord_t    MinMaxRes,
   output logic       CmpNV
);

   logic xNaN, yNaN, xSNaN, ySNaN;
   logic bothZero, xLtY, eq, lt;

   assign xNaN  = &FSrcX[30:23] & |FSrcX[22:0];
   assign yNaN  = &FSrcY[30:23] & |FSrcY[22:0];
   assign xSNaN = xNaN & ~FSrcX[22];        // quiet bit clear
   assign ySNaN = yNaN & ~FSrcY[22];
   assign bothZero = ~|{FSrcX[30:0], FSrcY[30:0]};

   // total order on sign-magnitude words, -0 below +0
   always_comb begin
      case ({FSrcX[31], FSrcY[31]})
         2'b10:   xLtY = 1'b1;
         2'b01:   xLtY = 1'b0;
         2'b00:   xLtY = FSrcX[30:0] < FSrcY[30:0];
         default: xLtY = FSrcX[30:0] > FSrcY[30:0];   // both negative
      endcase
   end

   assign eq = bothZero | (FSrcX == FSrcY);   // signed zeros compare equal
   assign lt = xLtY & ~bothZero;

   always_comb begin
      CmpIntRes = '0;
      if (!(xNaN || yNaN)) begin
         case (FOpCtrl[1:0])
            2'b10:   CmpIntRes[0] = eq;
            2'b01:   CmpIntRes[0] = lt;
            default: CmpIntRes[0] = lt | eq;
         endcase
      end
   end

   // feq, fmin, fmax only trap on signaling NaN
   assign CmpNV = (FOpCtrl[2] | FOpCtrl[1]) ? (xSNaN | ySNaN) : (xNaN | yNaN);

   always_comb begin
      if (xNaN && yNaN)  MinMaxRes = canonNaN;
      else if (xNaN)     MinMaxRes = FSrcY;          // a lone NaN loses
      else if (yNaN)     MinMaxRes = FSrcX;
      else if (FOpCtrl[0]) MinMaxRes = xLtY ? FSrcY : FSrcX;   // max
      else               MinMaxRes = xLtY ? FSrcX : FSrcY;
   end

endmodule

// ==== verilog/fpHazard.sv ====
`timescale 1ns/1ps
// fpHazard
// forwarding selects for the three execute sources and the load-use stall
// memory stage wins over writeback, a load in memory is never a source

module fpHazard import fpuPkg::*; (
   input  regAdr_t Adr1D, Adr2D,
   input  regAdr_t Adr1E, Adr2E, Adr3E,
   input  logic    FpLoadE,
   input  regAdr_t RdE,
   input  logic    FRegWriteM,
   input  logic    FpLoadM,
   input  regAdr_t RdM,
   input  logic    FRegWriteW,
   input  regAdr_t RdW,
   output fwdSel_t ForwardXE, ForwardYE, ForwardZE,
   output logic    FStallD
);

   function automatic fwdSel_t fwdFor(regAdr_t adr);
      if (FRegWriteM && !FpLoadM && RdM == adr) return fwdMem;  // load data not here yet
      if (FRegWriteW && RdW == adr) return fwdWb;
      return fwdReg;
   endfunction

   always_comb begin
      ForwardXE = fwdFor(Adr1E);
      ForwardYE = fwdFor(Adr2E);
      ForwardZE = fwdFor(Adr3E);   // store data
   end

   // flw in E feeds D, hold D one cycle so the data comes from writeback
   assign FStallD = FpLoadE && (RdE == Adr1D || RdE == Adr2D);

endmodule

// ==== verilog/fpRegFile.sv ====
`timescale 1ns/1ps
// fpRegFile
// 32 x 32-bit FP register file
// three combinational read ports, one write port, write-through on a
// read of the address being written

module fpRegFile import fpuPkg::*; (
   input  logic    clk,
   input  logic    rstN,
   input  regAdr_t Adr1, Adr2, Adr3,
   input  logic    WriteEn,
   input  regAdr_t WriteAdr,
   input  fpWord_t WriteData,
   output fpWord_t ReadData1, ReadData2, ReadData3
);

   fpWord_t regs [32];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 32; i++) regs[i] <= '0;   // all registers start at +0
      end else if (WriteEn) begin
         regs[WriteAdr] <= WriteData;
      end
   end

   // bypass the write so decode sees the value retired this cycle
   assign ReadData1 = (WriteEn && WriteAdr == Adr1) ? WriteData : regs[Adr1];
   assign ReadData2 = (WriteEn && WriteAdr == Adr2) ? WriteData : regs[Adr2];
   assign ReadData3 = (WriteEn && WriteAdr == Adr3) ? WriteData : regs[Adr3];

   // writeback never retires an undefined result
   assert property (@(posedge clk) disable iff (!rstN) WriteEn |-> !$isunknown(WriteData))
      else $error("FP register write with unknown data");

endmodule

// ==== verilog/fpSignClassify.sv ====
`timescale 1ns/1ps
// fpSignClassify
// sign injection (fsgnj, fsgnjn, fsgnjx) and the ten-bit fclass mask

module fpSignClassify import fpuPkg::*; (
   input  fpWord_t    FSrcX, FSrcY,
   input  logic [1:0] FOpCtrl,      // 00 j, 01 jn, 10 jx
   output fpWord_t    SgnRes,
   output fpWord_t    ClassRes
);

   logic sgn, s;
   logic expOnes, expZero, fracZero;
   logic isInf, isNaN, isZero, isSub, isNorm;

   always_comb begin
      case (FOpCtrl)
         2'b00:   sgn = FSrcY[31];
         2'b01:   sgn = ~FSrcY[31];
         default: sgn = FSrcX[31] ^ FSrcY[31];
      endcase
   end

   assign SgnRes = {sgn, FSrcX[30:0]};     // magnitude of X kept as is

   // classify X
   assign s        = FSrcX[31];
   assign expOnes  = &FSrcX[30:23];
   assign expZero  = ~|FSrcX[30:23];
   assign fracZero = ~|FSrcX[22:0];

   assign isInf  = expOnes & fracZero;
   assign isNaN  = expOnes & ~fracZero;
   assign isZero = expZero & fracZero;
   assign isSub  = expZero & ~fracZero;
   assign isNorm = ~expZero & ~expOnes;

   // bit 0 is -inf, bit 9 is qNaN
   assign ClassRes = {22'b0,
                      isNaN & FSrcX[22], isNaN & ~FSrcX[22],
                      ~s & isInf, ~s & isNorm, ~s & isSub, ~s & isZero,
                      s & isZero, s & isSub, s & isNorm, s & isInf};

endmodule

// ==== verilog/fpuDecode.sv ====
`timescale 1ns/1ps
// fpuDecode
// decode stage of the FPU
// turns the instruction word into stage control and flags every
// encoding outside the kept RV32F subset as illegal

module fpuDecode import fpuPkg::*; (
   input  fpWord_t    InstrD,
   output logic       FRegWriteD,        // writes an FP register
   output logic       FWriteIntD,        // writes an integer register
   output logic       FpStoreD,
   output logic       FpLoadD,
   output fpResSel_t  FpResSelD,
   output intResSel_t IntResSelD,
   output logic [2:0] FOpCtrlD,
   output regAdr_t    RdD,
   output logic       IllegalFPUInstrD
);

   logic [6:0] op, f7;
   logic [2:0] f3;
   logic [4:0] rs2;

   assign op  = InstrD[6:0];
   assign f3  = InstrD[14:12];
   assign f7  = InstrD[31:25];
   assign rs2 = InstrD[24:20];

   assign RdD      = InstrD[11:7];
   assign FOpCtrlD = {f7 == f7MinMax, f3[1:0]};  // [2] min/max, [1:0] sign op or compare kind

   always_comb begin
      FRegWriteD       = 1'b0;
      FWriteIntD       = 1'b0;
      FpStoreD         = 1'b0;
      FpLoadD          = 1'b0;
      FpResSelD        = fpResSgn;
      IntResSelD       = intResCmp;
      IllegalFPUInstrD = 1'b1;           // cleared on a match
      case (op)
         opLoadFp: if (f3 == 3'b010) begin
            {FRegWriteD, FpLoadD, IllegalFPUInstrD} = 3'b110;
            FpResSelD = fpResLoad;
         end
         opStoreFp: if (f3 == 3'b010) begin
            {FpStoreD, IllegalFPUInstrD} = 2'b10;
         end
         opFp: case (f7)
            f7SgnJ: if (f3 < 3'd3) begin       // j, jn, jx
               {FRegWriteD, IllegalFPUInstrD} = 2'b10;
            end
            f7MinMax: if (f3 < 3'd2) begin     // min, max
               {FRegWriteD, IllegalFPUInstrD} = 2'b10;
               FpResSelD = fpResMinMax;
            end
            f7Cmp: if (f3 < 3'd3) begin        // le, lt, eq
               {FWriteIntD, IllegalFPUInstrD} = 2'b10;
            end
            f7ClassMvX: if (rs2 == 5'd0 && f3 < 3'd2) begin
               {FWriteIntD, IllegalFPUInstrD} = 2'b10;
               IntResSelD = f3[0] ? intResClass : intResMv;
            end
            f7MvW: if (rs2 == 5'd0 && f3 == 3'd0) begin
               {FRegWriteD, IllegalFPUInstrD} = 2'b10;
               FpResSelD = fpResMvW;
            end
            default: ;
         endcase
         default: ;
      endcase
   end

endmodule

// ==== verilog/fpuExecute.sv ====
`timescale 1ns/1ps
// fpuExecute
// D/E register, operand forwarding, compare and sign/classify units,
// result selection and the E/M register
// a stall from the hazard unit turns the D/E load into a bubble

module fpuExecute import fpuPkg::*; (
   input  logic       clk,
   input  logic       rstN,
   input  logic       FStallD,
   input  logic       FRegWriteD, FWriteIntD, FpStoreD, FpLoadD,
   input  fpResSel_t  FpResSelD,
   input  intResSel_t IntResSelD,
   input  logic [2:0] FOpCtrlD,
   input  regAdr_t    RdD, Adr1D, Adr2D, Adr3D,
   input  fpWord_t    ReadData1, ReadData2, ReadData3,
   input  fwdSel_t    ForwardXE, ForwardYE, ForwardZE,
   input  fpWord_t    ForwardedSrcAE,   // integer source of fmv.w.x
   input  fpWord_t    FPUResultW,
   output regAdr_t    Adr1E, Adr2E, Adr3E,
   output regAdr_t    RdE,
   output logic       FpLoadE,
   output logic       FpStoreE,
   output fpWord_t    FWriteDataE,
   output logic       FRegWriteM,
   output logic       FpLoadM,
   output regAdr_t    RdM,
   output fpWord_t    FpResM,
   output logic       FWriteIntM,
   output fpWord_t    FIntResM,
   output logic       FpLoadStoreM,
   output logic       PreNVM
);

   logic       fRegWriteE, fWriteIntE;
   fpResSel_t  fpResSelE;
   intResSel_t intResSelE;
   logic [2:0] fOpCtrlE;
   fpWord_t    rd1E, rd2E, rd3E;
   fpWord_t    fSrcXE, fSrcYE;
   fpWord_t    cmpIntResE, minMaxResE, sgnResE, classResE;
   fpWord_t    fpResE, intResE;
   logic       cmpNVE, preNVE;

   //////////////////////////////////////////////////////////////////////
   // D/E register

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         {fRegWriteE, fWriteIntE, FpStoreE, FpLoadE} <= '0;
      end else begin   // bubble while decode is held
         {fRegWriteE, fWriteIntE, FpStoreE, FpLoadE} <=
            FStallD ? 4'b0 : {FRegWriteD, FWriteIntD, FpStoreD, FpLoadD};
      end
   end

   always_ff @(posedge clk) begin
      {fpResSelE, intResSelE, fOpCtrlE} <= {FpResSelD, IntResSelD, FOpCtrlD};
      {RdE, Adr1E, Adr2E, Adr3E}        <= {RdD, Adr1D, Adr2D, Adr3D};
      {rd1E, rd2E, rd3E}                <= {ReadData1, ReadData2, ReadData3};
   end

   //////////////////////////////////////////////////////////////////////
   // forwarding and execute units

   function automatic fpWord_t fwdMux(fwdSel_t sel, fpWord_t rf, fpWord_t mem, fpWord_t wb);
      case (sel)
         fwdMem:  return mem;
         fwdWb:   return wb;
         default: return rf;
      endcase
   endfunction

   assign fSrcXE      = fwdMux(ForwardXE, rd1E, FpResM, FPUResultW);
   assign fSrcYE      = fwdMux(ForwardYE, rd2E, FpResM, FPUResultW);
   assign FWriteDataE = fwdMux(ForwardZE, rd3E, FpResM, FPUResultW);   // fsw data to memory

   fpCompare fpCompare (.FSrcX(fSrcXE), .FSrcY(fSrcYE), .FOpCtrl(fOpCtrlE),
      .CmpIntRes(cmpIntResE), .MinMaxRes(minMaxResE), .CmpNV(cmpNVE));

   fpSignClassify fpSignClassify (.FSrcX(fSrcXE), .FSrcY(fSrcYE), .FOpCtrl(fOpCtrlE[1:0]),
      .SgnRes(sgnResE), .ClassRes(classResE));

   always_comb begin
      case (fpResSelE)
         fpResSgn:    fpResE = sgnResE;
         fpResMinMax: fpResE = minMaxResE;
         fpResMvW:    fpResE = ForwardedSrcAE;
         default:     fpResE = '0;            // load, replaced in writeback
      endcase
      case (intResSelE)
         intResCmp:   intResE = cmpIntResE;
         intResClass: intResE = classResE;
         default:     intResE = fSrcXE;       // fmv.x.w raw bits
      endcase
   end

   // only compares and min/max report invalid
   assign preNVE = cmpNVE & ((fWriteIntE & intResSelE == intResCmp) |
                             (fRegWriteE & fpResSelE == fpResMinMax));

   //////////////////////////////////////////////////////////////////////
   // E/M register

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         {FRegWriteM, FpLoadM, FWriteIntM, FpLoadStoreM, PreNVM} <= '0;
      end else begin
         {FRegWriteM, FpLoadM, FWriteIntM} <= {fRegWriteE, FpLoadE, fWriteIntE};
         FpLoadStoreM <= FpLoadE | FpStoreE;
         PreNVM       <= preNVE;
      end
   end

   always_ff @(posedge clk) begin
      RdM      <= RdE;
      FpResM   <= fpResE;
      FIntResM <= intResE;
   end

   // the bubble clears the load in E, so a stall never repeats
   assert property (@(posedge clk) disable iff (!rstN) FStallD |=> !FStallD)
      else $error("load-use stall held for more than one cycle");

endmodule

// ==== verilog/fpuPkg.sv ====
// fpuPkg
// shared constants and types of the single-precision FPU pipeline
// RV32F opcodes and funct7 codes, result selects, forwarding selects

package fpuPkg;

   typedef logic [31:0] fpWord_t;   // single-precision value or integer word
   typedef logic [4:0]  regAdr_t;   // register address

   // major opcodes
   localparam logic [6:0] opLoadFp  = 7'b0000111;  // flw
   localparam logic [6:0] opStoreFp = 7'b0100111;  // fsw
   localparam logic [6:0] opFp      = 7'b1010011;  // OP-FP group

   // funct7, single precision only
   localparam logic [6:0] f7SgnJ     = 7'b0010000;
   localparam logic [6:0] f7MinMax   = 7'b0010100;
   localparam logic [6:0] f7Cmp      = 7'b1010000;
   localparam logic [6:0] f7ClassMvX = 7'b1110000;  // fclass or fmv.x.w, split by funct3
   localparam logic [6:0] f7MvW      = 7'b1111000;

   // result bound for the FP register
   typedef enum logic [1:0] {
      fpResSgn    = 2'd0,
      fpResMinMax = 2'd1,
      fpResMvW    = 2'd2,   // integer source moved in
      fpResLoad   = 2'd3    // data arrives in writeback
   } fpResSel_t;

   // result bound for the integer register
   typedef enum logic [1:0] {
      intResCmp   = 2'd0,
      intResClass = 2'd1,
      intResMv    = 2'd2
   } intResSel_t;

   typedef enum logic [1:0] {
      fwdReg = 2'd0,   // value read in decode
      fwdMem = 2'd1,
      fwdWb  = 2'd2
   } fwdSel_t;

   localparam fpWord_t canonNaN  = 32'h7FC0_0000;  // positive quiet NaN, zero payload
   localparam int      nvFlagBit = 4;              // flags are {NV, DZ, OF, UF, NX}

endpackage

// ==== verilog/fpuResult.sv ====
`timescale 1ns/1ps
// fpuResult
// memory-stage flag output, M/W register and the writeback mux
// between the FP result and the load data

module fpuResult import fpuPkg::*; (
   input  logic       clk,
   input  logic       rstN,
   input  logic       FRegWriteM,
   input  logic       FpLoadM,
   input  regAdr_t    RdM,
   input  fpWord_t    FpResM,
   input  logic       PreNVM,
   input  fpWord_t    ReadDataW,      // load data from the core
   output logic [4:0] SetFflagsM,
   output logic       FRegWriteW,
   output regAdr_t    RdW,
   output fpWord_t    FPUResultW
);

   logic    fpLoadW;
   fpWord_t fpResW;

   always_comb begin
      SetFflagsM            = '0;       // no DZ, OF, UF or NX in this subset
      SetFflagsM[nvFlagBit] = PreNVM;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         {FRegWriteW, fpLoadW} <= '0;
      end else begin
         {FRegWriteW, fpLoadW} <= {FRegWriteM, FpLoadM};
      end
   end

   always_ff @(posedge clk) begin
      RdW    <= RdM;
      fpResW <= FpResM;
   end

   assign FPUResultW = fpLoadW ? ReadDataW : fpResW;

endmodule

// ==== verilog/fpuTop.sv ====
`timescale 1ns/1ps
// fpuTop
// single-precision FPU pipeline, decode through writeback
// decode, register file, hazard unit, execute and result stages

module fpuTop import fpuPkg::*; (
   input  logic       clk,
   input  logic       rstN,
   input  fpWord_t    InstrD,
   input  fpWord_t    ForwardedSrcAE,  // integer source, valid in execute
   input  fpWord_t    ReadDataW,       // load data, valid in writeback
   output logic       FStallD,
   output logic       IllegalFPUInstrD,
   output logic       FpStoreE,
   output fpWord_t    FWriteDataE,
   output logic       FWriteIntM,
   output fpWord_t    FIntResM,
   output logic       FpLoadStoreM,
   output logic [4:0] SetFflagsM
);

   logic       fRegWriteD, fWriteIntD, fpStoreD, fpLoadD;
   fpResSel_t  fpResSelD;
   intResSel_t intResSelD;
   logic [2:0] fOpCtrlD;
   regAdr_t    rdD, rdE, rdM, rdW;
   regAdr_t    adr1E, adr2E, adr3E;
   fpWord_t    readData1, readData2, readData3;
   fwdSel_t    forwardXE, forwardYE, forwardZE;
   logic       fpLoadE, fRegWriteM, fpLoadM, fRegWriteW, preNVM;
   fpWord_t    fpResM, fpuResultW;

   fpuDecode fpuDecode (.InstrD, .FRegWriteD(fRegWriteD), .FWriteIntD(fWriteIntD),
      .FpStoreD(fpStoreD), .FpLoadD(fpLoadD), .FpResSelD(fpResSelD), .IntResSelD(intResSelD),
      .FOpCtrlD(fOpCtrlD), .RdD(rdD), .IllegalFPUInstrD);

   // port 3 reads the rs2 field as fsw store data
   fpRegFile fpRegFile (.clk, .rstN, .Adr1(InstrD[19:15]), .Adr2(InstrD[24:20]),
      .Adr3(InstrD[24:20]), .WriteEn(fRegWriteW), .WriteAdr(rdW), .WriteData(fpuResultW),
      .ReadData1(readData1), .ReadData2(readData2), .ReadData3(readData3));

   fpHazard fpHazard (.Adr1D(InstrD[19:15]), .Adr2D(InstrD[24:20]),
      .Adr1E(adr1E), .Adr2E(adr2E), .Adr3E(adr3E), .FpLoadE(fpLoadE), .RdE(rdE),
      .FRegWriteM(fRegWriteM), .FpLoadM(fpLoadM), .RdM(rdM), .FRegWriteW(fRegWriteW),
      .RdW(rdW), .ForwardXE(forwardXE), .ForwardYE(forwardYE), .ForwardZE(forwardZE),
      .FStallD);

   fpuExecute fpuExecute (.clk, .rstN, .FStallD,
      .FRegWriteD(fRegWriteD), .FWriteIntD(fWriteIntD), .FpStoreD(fpStoreD), .FpLoadD(fpLoadD),
      .FpResSelD(fpResSelD), .IntResSelD(intResSelD), .FOpCtrlD(fOpCtrlD), .RdD(rdD),
      .Adr1D(InstrD[19:15]), .Adr2D(InstrD[24:20]), .Adr3D(InstrD[24:20]),
      .ReadData1(readData1), .ReadData2(readData2), .ReadData3(readData3),
      .ForwardXE(forwardXE), .ForwardYE(forwardYE), .ForwardZE(forwardZE),
      .ForwardedSrcAE, .FPUResultW(fpuResultW),
      .Adr1E(adr1E), .Adr2E(adr2E), .Adr3E(adr3E), .RdE(rdE), .FpLoadE(fpLoadE),
      .FpStoreE, .FWriteDataE, .FRegWriteM(fRegWriteM), .FpLoadM(fpLoadM), .RdM(rdM),
      .FpResM(fpResM), .FWriteIntM, .FIntResM, .FpLoadStoreM, .PreNVM(preNVM));

   fpuResult fpuResult (.clk, .rstN, .FRegWriteM(fRegWriteM), .FpLoadM(fpLoadM), .RdM(rdM),
      .FpResM(fpResM), .PreNVM(preNVM), .ReadDataW, .SetFflagsM,
      .FRegWriteW(fRegWriteW), .RdW(rdW), .FPUResultW(fpuResultW));

endmodule
